// ==== source/wsg_pkg.sv ====
package wsg_pkg;

	////////////////////////////////////////
	// sizes and address map
	////////////////////////////////////////
	localparam int NUM_VOICES = 8;
	localparam int WAVE_LEN   = 64;                 // samples per voice
	localparam int POS_W      = $clog2(WAVE_LEN);   // wave position width
	localparam int ADDR_W     = 10;                 // byte address, 1 KiB window

	// voice word v lives at VOICE_BASE + 4v, wave ram fills everything below
	localparam logic [ADDR_W-1:0] VOICE_BASE = ADDR_W'('h200);

	////////////////////////////////////////
	// bus structs
	////////////////////////////////////////
	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [ADDR_W-1:0] paddr;
		logic [31:0]       pwdata;
		logic [3:0]        pstrb;   // strb[3] -> bits 31..24
	} apb_req_t;

	typedef struct packed {
		logic        pready;
		logic [31:0] prdata;
		logic        pslverr;
	} apb_rsp_t;

	////////////////////////////////////////
	// voice and datapath structs
	////////////////////////////////////////
	// same layout as the bus word, msb first
	typedef struct packed {
		logic [7:0] freq_lo;
		logic [7:0] freq_hi;
		logic [3:0] vol_l0;
		logic [3:0] vol_l1;
		logic [3:0] vol_r0;
		logic [3:0] vol_r1;
	} voice_cfg_t;

	typedef voice_cfg_t [NUM_VOICES-1:0] voice_cfg_arr_t;

	typedef logic [NUM_VOICES-1:0][POS_W-1:0] wave_pos_arr_t;

	typedef struct packed {
		logic       active; // high for the 256 schedule steps after a frame wrap
		logic [7:0] step;
	} seq_step_t;

	typedef struct packed {
		logic [6:0]  idx;   // word index, {voice, pos[5:2]}
		logic [3:0]  be;    // all zero means no write
		logic [31:0] data;
	} ram_wr_t;

	typedef struct packed {
		logic signed [15:0] left;
		logic signed [15:0] right;
	} stereo_t;

endpackage

// ==== source/wsg_apb_regs.sv ====
`timescale 1ns/1ns

module wsg_apb_regs (
	input  logic                    i_Clk,
	input  logic                    i_arst_n,
	input  wsg_pkg::apb_req_t       i_apb,
	output wsg_pkg::apb_rsp_t       o_apb,
	output wsg_pkg::ram_wr_t        o_ram_wr,
	output logic [6:0]              o_ram_rd_idx,
	input  logic [31:0]             i_ram_rd_data,
	output wsg_pkg::voice_cfg_arr_t o_voice_cfg
);

	////////////////////////////////////////
	// address decode
	////////////////////////////////////////
	logic                        access;     // apb access phase
	logic                        wr_access;
	logic                        rd_access;
	logic                        in_wave;    // 0x000..0x1ff
	logic                        in_voice;   // 0x200..0x21f
	logic                        in_undef;
	logic [wsg_pkg::ADDR_W-1:0]  voice_off;  // byte offset from the voice base
	logic [2:0]                  voice_idx;
	logic [31:0]                 rd_word;

	wsg_pkg::voice_cfg_arr_t     voice_q;    // the eight voice words

	assign access    = i_apb.psel && i_apb.penable;
	assign wr_access = access && i_apb.pwrite;
	assign rd_access = access && !i_apb.pwrite;

	// wave ram is everything below the voice block
	assign in_wave   = (i_apb.paddr < wsg_pkg::VOICE_BASE);
	assign voice_off = i_apb.paddr - wsg_pkg::VOICE_BASE;
	assign in_voice  = !in_wave &&
		(voice_off < wsg_pkg::ADDR_W'(wsg_pkg::NUM_VOICES * 4));
	assign in_undef  = !in_wave && !in_voice;
	assign voice_idx = voice_off[4:2]; // word granular, low two bits ignored

	////////////////////////////////////////
	// wave ram port
	////////////////////////////////////////
	// word index straight from the byte address, 16 words per voice
	assign o_ram_rd_idx  = i_apb.paddr[8:2];
	assign o_ram_wr.idx  = i_apb.paddr[8:2];
	assign o_ram_wr.data = i_apb.pwdata;
	assign o_ram_wr.be   = (wr_access && in_wave) ? i_apb.pstrb : 4'b0000;

	////////////////////////////////////////
	// voice registers
	////////////////////////////////////////
	always_ff @(posedge i_Clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			voice_q <= '0; // every voice starts silent at freq 0
		end else if (wr_access && in_voice) begin
			for (int b = 0; b < 4; b++) begin
				if (i_apb.pstrb[b]) begin
					voice_q[voice_idx][8*b +: 8] <= i_apb.pwdata[8*b +: 8];
				end
			end
		end
	end

	assign o_voice_cfg = voice_q;

	////////////////////////////////////////
	// read mux and response
	////////////////////////////////////////
	always_comb begin
		rd_word = 32'd0; // undefined space reads zero
		if (in_wave) begin
			rd_word = i_ram_rd_data; // async ram read, same cycle
		end else if (in_voice) begin
			rd_word = voice_q[voice_idx];
		end
	end

	always_comb begin
		o_apb.pready  = 1'b1;                        // never any wait states
		o_apb.prdata  = rd_access ? rd_word : 32'd0; // bus idles at zero
		o_apb.pslverr = access && in_undef;          // reads and writes alike
	end

endmodule

// ==== source/wsg_wave_ram.sv ====
`timescale 1ns/1ns

module wsg_wave_ram (
	input  logic               i_Clk,
	input  wsg_pkg::ram_wr_t   i_ram_wr,
	input  logic [6:0]         i_bus_rd_idx,
	output logic [31:0]        o_bus_rd_data,
	input  logic [2:0]         i_mix_voice,
	input  logic [5:0]         i_mix_pos,
	output logic signed [7:0]  o_mix_sample
);

	// lane 0 holds samples 0,4,8.. and sits in bits 31..24 of the word
	logic [7:0] lane_mem [4][128];
	logic [6:0] mix_idx;

	assign mix_idx = {i_mix_voice, i_mix_pos[5:2]};

	// bus write, one enable per byte lane
	always_ff @(posedge i_Clk) begin
		for (int b = 0; b < 4; b++) begin
			if (i_ram_wr.be[3-b]) begin
				lane_mem[b][i_ram_wr.idx] <= i_ram_wr.data[31-8*b -: 8];
			end
		end
	end

	// bus read is asynchronous so prdata is ready in the access phase
	assign o_bus_rd_data = {lane_mem[0][i_bus_rd_idx], lane_mem[1][i_bus_rd_idx],
		lane_mem[2][i_bus_rd_idx], lane_mem[3][i_bus_rd_idx]};

	// mixer read, registered, pos[1:0] picks the lane
	always_ff @(posedge i_Clk) begin
		o_mix_sample <= $signed(lane_mem[i_mix_pos[1:0]][mix_idx]);
	end

endmodule

// ==== source/wsg_sequencer.sv ====
`timescale 1ns/1ns

module wsg_sequencer #(
	parameter int FRAME_CYCLES = 256 // must be >= 256 to fit the schedule
) (
	input  logic                i_Clk,
	input  logic                i_arst_n,
	output wsg_pkg::seq_step_t  o_step
);

	localparam int CNT_W = $clog2(FRAME_CYCLES);

	logic [CNT_W-1:0] frame_cnt;
	logic             frame_wrap;

	assign frame_wrap = (frame_cnt == CNT_W'(FRAME_CYCLES - 1));

	// frame timer, stands in for the audio sample clock
	always_ff @(posedge i_Clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			frame_cnt <= '0;
		end else begin
			frame_cnt <= frame_wrap ? '0 : frame_cnt + 1'b1;
		end
	end

	// schedule: 256 steps from each wrap, then idle until the next one
	always_ff @(posedge i_Clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_step <= '0;
		end else if (frame_wrap) begin
			o_step.active <= 1'b1; // wins over step 255 when the frame is exactly 256
			o_step.step   <= 8'd0;
		end else if (o_step.active) begin
			o_step.active <= (o_step.step != 8'd255);
			o_step.step   <= o_step.step + 8'd1; // rolls to 0 while idle
		end
	end

endmodule

// ==== source/wsg_phase.sv ====
`timescale 1ns/1ns

module wsg_phase (
	input  logic                    i_Clk,
	input  logic                    i_arst_n,
	input  wsg_pkg::seq_step_t      i_step,
	input  wsg_pkg::voice_cfg_arr_t i_voice_cfg,
	output wsg_pkg::wave_pos_arr_t  o_wave_pos
);

	////////////////////////////////////////
	// per-voice phase state
	////////////////////////////////////////
	logic [21:0]            acc_q [wsg_pkg::NUM_VOICES]; // 16 fraction bits + 6 overflow bits
	wsg_pkg::wave_pos_arr_t pos_q;

	logic                   upd_win;  // steps 0..15
	logic [2:0]             v;        // voice under update
	wsg_pkg::voice_cfg_t    cfg;
	logic [21:0]            freq_ext; // freq << 5

	assign upd_win  = i_step.active && (i_step.step[7:4] == 4'd0);
	assign v        = i_step.step[3:1]; // two steps per voice
	assign cfg      = i_voice_cfg[v];
	assign freq_ext = {1'b0, cfg.freq_hi, cfg.freq_lo, 5'd0};

	always_ff @(posedge i_Clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < wsg_pkg::NUM_VOICES; i++) begin
				acc_q[i] <= '0;
			end
			pos_q <= '0;
		end else if (upd_win) begin
			if (!i_step.step[0]) begin
				// even step: accumulate, can overflow into bits 21..16
				acc_q[v] <= acc_q[v] + freq_ext;
			end else begin
				// odd step: every overflow moves the wave one sample on
				pos_q[v]        <= pos_q[v] + acc_q[v][21:16]; // wraps at 64
				acc_q[v][21:16] <= 6'd0;
			end
		end
	end

	// freq 0x0800 -> 0x10000 per frame -> exactly one sample per frame

	assign o_wave_pos = pos_q;

endmodule

// ==== source/wsg_mixer.sv ====
`timescale 1ns/1ns

module wsg_mixer (
	input  logic                    i_Clk,
	input  logic                    i_arst_n,
	input  wsg_pkg::seq_step_t      i_step,
	input  wsg_pkg::voice_cfg_arr_t i_voice_cfg,
	input  wsg_pkg::wave_pos_arr_t  i_wave_pos,
	output logic [2:0]              o_mix_voice,
	output logic [5:0]              o_mix_pos,
	input  logic signed [7:0]       i_mix_sample,
	output wsg_pkg::stereo_t        o_stereo,
	output logic                    o_sample_valid
);

	////////////////////////////////////////
	// schedule decode
	////////////////////////////////////////
	logic                in_left;    // steps 32..95
	logic                in_right;   // steps 128..191
	logic                in_mix;
	logic [7:0]          off_l;
	logic [5:0]          off;        // step offset inside the channel window
	logic [2:0]          slot_voice;
	logic                slot_nyb;   // 0 -> nybble 0, 1 -> nybble 1
	logic [1:0]          sub;        // stage within the four-step slot
	logic                at_96;
	logic                at_192;
	wsg_pkg::voice_cfg_t cfg;
	logic [3:0]          n0;
	logic [3:0]          n1;

	assign in_left    = i_step.active && (i_step.step >= 8'd32) && (i_step.step < 8'd96);
	assign in_right   = i_step.active && (i_step.step >= 8'd128) && (i_step.step < 8'd192);
	assign in_mix     = in_left || in_right;
	assign off_l      = i_step.step - 8'd32;
	assign off        = in_right ? i_step.step[5:0] : off_l[5:0];
	assign slot_voice = off[5:3];
	assign slot_nyb   = off[2];
	assign sub        = off[1:0];
	assign at_96      = i_step.active && (i_step.step == 8'd96);
	assign at_192     = i_step.active && (i_step.step == 8'd192);

	// channel nybbles of the voice in the current slot
	assign cfg = i_voice_cfg[slot_voice];
	assign n0  = in_right ? cfg.vol_r0 : cfg.vol_l0;
	assign n1  = in_right ? cfg.vol_r1 : cfg.vol_l1;

	////////////////////////////////////////
	// slot pipeline
	////////////////////////////////////////
	logic [2:0]         voice_q;
	logic [5:0]         pos_q;
	logic [3:0]         nyb_q;
	logic               mute_q;     // both channel nybbles zero
	logic [3:0]         nyb_inv_q;  // shift amount, larger volume -> smaller shift
	logic signed [7:0]  sample_q;
	logic signed [23:0] samp_ext;
	logic signed [23:0] contrib;

	always_ff @(posedge i_Clk) begin
		if (in_mix) begin
			case (sub)
				2'd0: begin // stage 1, pick voice, position, nybble
					voice_q <= slot_voice;
					pos_q   <= i_wave_pos[slot_voice];
					nyb_q   <= slot_nyb ? n1 : n0;
					mute_q  <= (n0 == 4'd0) && (n1 == 4'd0);
				end
				2'd2: begin // stage 2, ram answered during sub 1
					sample_q  <= i_mix_sample;
					nyb_inv_q <= ~nyb_q;
				end
				default: ; // sub 1 is the ram read, sub 3 the add
			endcase
		end
	end

	assign o_mix_voice = voice_q;
	assign o_mix_pos   = pos_q;

	// sample as a 9-bit signed value sitting 15 bits up, then scaled down
	assign samp_ext = $signed({sample_q[7], sample_q, 15'd0});
	assign contrib  = samp_ext >>> nyb_inv_q;

	////////////////////////////////////////
	// accumulate and publish
	////////////////////////////////////////
	logic signed [23:0] acc_q;   // shared by both channels in turn
	logic signed [15:0] left_q;

	always_ff @(posedge i_Clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			acc_q          <= '0;
			left_q         <= '0;
			o_stereo       <= '0;
			o_sample_valid <= 1'b0;
		end else begin
			o_sample_valid <= 1'b0;
			if (in_mix && (sub == 2'd3) && !mute_q) begin
				acc_q <= acc_q + contrib; // stage 3
			end
			if (at_96) begin // left done, free the accumulator for the right
				left_q <= acc_q[23:8];
				acc_q  <= '0;
			end
			if (at_192) begin
				o_stereo.left  <= left_q;
				o_stereo.right <= acc_q[23:8];
				acc_q          <= '0;
				o_sample_valid <= 1'b1; // lines up with the new pair
			end
		end
	end

endmodule

// ==== source/wsg_top.sv ====
`timescale 1ns/1ns

module wsg_top #(
	parameter int FRAME_CYCLES = 256 // frame length in i_Clk cycles, >= 256
) (
	input  logic              i_Clk,
	input  logic              i_arst_n,
	input  wsg_pkg::apb_req_t i_apb,
	output wsg_pkg::apb_rsp_t o_apb,
	output wsg_pkg::stereo_t  o_stereo,
	output logic              o_sample_valid
);

	////////////////////////////////////////
	// interconnect
	////////////////////////////////////////
	wsg_pkg::ram_wr_t        ram_wr;
	logic [6:0]              ram_rd_idx;
	logic [31:0]             ram_rd_data;
	wsg_pkg::voice_cfg_arr_t voice_cfg;   // to phase and mixer
	wsg_pkg::seq_step_t      step;        // schedule broadcast
	wsg_pkg::wave_pos_arr_t  wave_pos;
	logic [2:0]              mix_voice;
	logic [5:0]              mix_pos;
	logic signed [7:0]       mix_sample;

	wsg_apb_regs u_apb_regs (
		.i_Clk         (i_Clk),
		.i_arst_n      (i_arst_n),
		.i_apb         (i_apb),
		.o_apb         (o_apb),
		.o_ram_wr      (ram_wr),
		.o_ram_rd_idx  (ram_rd_idx),
		.i_ram_rd_data (ram_rd_data),
		.o_voice_cfg   (voice_cfg)
	);

	wsg_wave_ram u_wave_ram (
		.i_Clk         (i_Clk),
		.i_ram_wr      (ram_wr),
		.i_bus_rd_idx  (ram_rd_idx),
		.o_bus_rd_data (ram_rd_data),
		.i_mix_voice   (mix_voice),
		.i_mix_pos     (mix_pos),
		.o_mix_sample  (mix_sample)
	);

	wsg_sequencer #(
		.FRAME_CYCLES (FRAME_CYCLES)
	) u_sequencer (
		.i_Clk    (i_Clk),
		.i_arst_n (i_arst_n),
		.o_step   (step)
	);

	wsg_phase u_phase (
		.i_Clk       (i_Clk),
		.i_arst_n    (i_arst_n),
		.i_step      (step),
		.i_voice_cfg (voice_cfg),
		.o_wave_pos  (wave_pos)
	);

	wsg_mixer u_mixer (
		.i_Clk          (i_Clk),
		.i_arst_n       (i_arst_n),
		.i_step         (step),
		.i_voice_cfg    (voice_cfg),
		.i_wave_pos     (wave_pos),
		.o_mix_voice    (mix_voice),
		.o_mix_pos      (mix_pos),
		.i_mix_sample   (mix_sample),
		.o_stereo       (o_stereo),
		.o_sample_valid (o_sample_valid)
	);

endmodule

// ==== tests/wsg_sva.sv ====
`timescale 1ns/1ns

module wsg_sva #(
	parameter int FRAME_CYCLES = 256
) (
	input logic              i_Clk,
	input logic              i_arst_n,
	input wsg_pkg::apb_req_t i_req,
	input wsg_pkg::apb_rsp_t i_rsp,
	input logic              i_valid  // o_sample_valid of the top
);

	// zero wait states, always
	a_pready : assert property (@(posedge i_Clk) disable iff (!i_arst_n) i_rsp.pready)
		else $error("pready dropped");

	a_valid_one : assert property (@(posedge i_Clk) disable iff (!i_arst_n)
		i_valid |=> !i_valid)
		else $error("sample valid longer than one cycle");

	// one pair per frame
	a_valid_period : assert property (@(posedge i_Clk) disable iff (!i_arst_n)
		i_valid |=> !i_valid [*FRAME_CYCLES-1] ##1 i_valid)
		else $error("sample valid pulses not one frame apart");

	a_slverr : assert property (@(posedge i_Clk) disable iff (!i_arst_n)
		i_rsp.pslverr |-> (i_req.psel && i_req.penable))
		else $error("pslverr outside an access phase");

endmodule

bind wsg_top wsg_sva #(.FRAME_CYCLES(FRAME_CYCLES)) u_sva (
	.i_Clk    (i_Clk),
	.i_arst_n (i_arst_n),
	.i_req    (i_apb),
	.i_rsp    (o_apb),
	.i_valid  (o_sample_valid)
);

// ==== tests/wsg_tb.sv ====
`timescale 1ns/1ns

module wsg_tb;

	localparam int FRAME_CYCLES = 256;

	logic              i_Clk;
	logic              i_arst_n;
	wsg_pkg::apb_req_t i_apb;
	wsg_pkg::apb_rsp_t o_apb;
	wsg_pkg::stereo_t  o_stereo;
	logic              o_sample_valid;

	// mirror of the register file and the wave ram, plus the phase model
	logic [31:0] voice_mir [8];
	logic [7:0]  wave_mir [8][64];
	logic [5:0]  pos_mdl [8];
	logic [21:0] acc_mdl [8];
	bit          check_en;        // low while the config is being changed
	int          frames;          // valid pulses seen
	integer      seed = 32'h8cda5d89;

	wsg_top #(.FRAME_CYCLES(FRAME_CYCLES)) u_wsg_top (
		.i_Clk          (i_Clk),
		.i_arst_n       (i_arst_n),
		.i_apb          (i_apb),
		.o_apb          (o_apb),
		.o_stereo       (o_stereo),
		.o_sample_valid (o_sample_valid)
	);

	initial begin
		i_Clk = 1'b0;
		forever #20 i_Clk = ~i_Clk; // 40 ns period
	end

	////////////////////////////////////////
	// checks and bus tasks
	////////////////////////////////////////
	task automatic stop_run;
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: %0t ns %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	function automatic logic [31:0] wave_word(input int w);
		return {wave_mir[w/16][4*(w%16)], wave_mir[w/16][4*(w%16)+1],
			wave_mir[w/16][4*(w%16)+2], wave_mir[w/16][4*(w%16)+3]};
	endfunction

	// one apb transfer, setup then access, mirror follows the address map
	task automatic apb_xfer(input logic wr, input logic [9:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [31:0] rd, output logic err);
		int n;
		int w;
		@(posedge i_Clk);
		#1;
		i_apb.psel    = 1'b1;
		i_apb.penable = 1'b0;
		i_apb.pwrite  = wr;
		i_apb.paddr   = addr;
		i_apb.pwdata  = data;
		i_apb.pstrb   = strb;
		@(posedge i_Clk);
		#1;
		i_apb.penable = 1'b1;
		n = 0;
		do begin
			@(posedge i_Clk);
			n++;
			if (n > 8) begin
				$display("APB transfer to address %h never saw pready", addr);
				stop_run();
			end
		end while (!o_apb.pready);
		rd  = o_apb.prdata;
		err = o_apb.pslverr;
		if (wr && addr < 10'h200) begin // wave ram, strb[3] is the lowest sample
			w = addr[8:2];
			for (int j = 0; j < 4; j++) begin
				if (strb[3-j]) wave_mir[w/16][4*(w%16)+j] = data[31-8*j -: 8];
			end
		end else if (wr && addr < 10'h220) begin
			for (int b = 0; b < 4; b++) begin
				if (strb[b]) voice_mir[addr[4:2]][8*b +: 8] = data[8*b +: 8];
			end
		end
		#1;
		i_apb.psel    = 1'b0;
		i_apb.penable = 1'b0;
	endtask

	task automatic apb_write(input logic [9:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic err);
		logic [31:0] rd;
		apb_xfer(1'b1, addr, data, strb, rd, err);
	endtask

	task automatic apb_read(input logic [9:0] addr, output logic [31:0] rd, output logic err);
		apb_xfer(1'b0, addr, 32'd0, 4'd0, rd, err);
	endtask

	// returns a little after the edge of the n-th next valid pulse
	task automatic wait_frames(input int n);
		int target;
		int t;
		target = frames + n;
		t = 0;
		while (frames < target) begin
			@(posedge i_Clk);
			#1;
			t++;
			if (t > 2*FRAME_CYCLES*n) begin
				$display("timed out waiting for a sample frame");
				stop_run();
			end
		end
	endtask

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////
	// inverted nybble is the shift, both nybbles zero mutes the voice
	function automatic logic [15:0] mix_channel(input bit right);
		logic signed [23:0] acc;
		logic signed [23:0] term;
		logic [3:0]         n0;
		logic [3:0]         n1;
		logic [7:0]         s;
		acc = '0;
		for (int v = 0; v < 8; v++) begin
			n0 = right ? voice_mir[v][7:4] : voice_mir[v][15:12];
			n1 = right ? voice_mir[v][3:0] : voice_mir[v][11:8];
			s  = wave_mir[v][pos_mdl[v]];
			if (n0 != 0 || n1 != 0) begin
				for (int k = 0; k < 2; k++) begin
					term = {{16{s[7]}}, s};
					term = term <<< 15;
					term = term >>> (4'd15 - (k ? n1 : n0));
					acc  = acc + term; // wraps at 24 bits like the hardware
				end
			end
		end
		return acc[23:8];
	endfunction

	// one phase update per frame, freq = {hi, lo}
	function automatic void advance_phase;
		logic [15:0] freq;
		for (int v = 0; v < 8; v++) begin
			freq       = {voice_mir[v][23:16], voice_mir[v][31:24]};
			acc_mdl[v] = acc_mdl[v] + {1'b0, freq, 5'd0};
			pos_mdl[v] = pos_mdl[v] + acc_mdl[v][21:16]; // mod 64
			acc_mdl[v][21:16] = 6'd0;
		end
	endfunction

	// checker: every valid pulse advances the model and compares both channels
	initial begin
		int n;
		forever begin
			n = 0;
			do begin
				@(posedge i_Clk);
				n++;
				if (n > 2*FRAME_CYCLES) begin
					$display("o_sample_valid did not arrive within two frames");
					stop_run();
				end
			end while (o_sample_valid !== 1'b1);
			if (frames == 0 && n < FRAME_CYCLES) begin
				$display("o_sample_valid came before the first frame was over");
				stop_run();
			end
			advance_phase();
			if (check_en) begin
				check_eq("o_stereo.left", $unsigned(o_stereo.left), mix_channel(1'b0));
				check_eq("o_stereo.right", $unsigned(o_stereo.right), mix_channel(1'b1));
			end
			frames++;
		end
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	initial begin
		logic [31:0] rd;
		logic        err;
		i_apb    = '0;
		i_arst_n = 1'b0;
		check_en = 1'b0;
		frames   = 0;
		for (int v = 0; v < 8; v++) begin
			voice_mir[v] = '0;
			pos_mdl[v]   = '0;
			acc_mdl[v]   = '0;
			for (int i = 0; i < 64; i++) wave_mir[v][i] = '0;
		end
		repeat (4) @(posedge i_Clk);
		#1 i_arst_n = 1'b1;

		// reset values
		check_eq("o_stereo", o_stereo, 32'd0);
		for (int v = 0; v < 8; v++) begin
			apb_read(wsg_pkg::VOICE_BASE + 10'(4*v), rd, err);
			check_eq("voice prdata", rd, 32'd0);
			check_eq("pslverr", err, 0);
		end

		// random waveforms, then partial strobes on both regions
		for (int w = 0; w < 128; w++) apb_write(10'(4*w), $random(seed), 4'hf, err);
		apb_write(10'h014, 32'h11223344, 4'b0101, err);
		apb_read(10'h014, rd, err);
		check_eq("wave prdata", rd, wave_word(5));
		apb_write(10'h1f8, 32'hcafef00d, 4'b1000, err);
		apb_read(10'h1f8, rd, err);
		check_eq("wave prdata", rd, wave_word(126));
		apb_write(wsg_pkg::VOICE_BASE + 10'h8, 32'hdeadbeef, 4'b0010, err);
		apb_write(wsg_pkg::VOICE_BASE + 10'h8, 32'h0000005a, 4'b0001, err);
		apb_read(wsg_pkg::VOICE_BASE + 10'h8, rd, err);
		check_eq("voice prdata", rd, voice_mir[2]);
		apb_write(10'h220, 32'hffffffff, 4'hf, err);
		check_eq("pslverr", err, 1);
		apb_read(10'h3fc, rd, err);
		check_eq("undefined prdata", rd, 32'd0);
		check_eq("pslverr", err, 1);

		// random volumes, freq lanes left at zero
		for (int v = 0; v < 8; v++) begin
			apb_write(wsg_pkg::VOICE_BASE + 10'(4*v), $random(seed), 4'b0011, err);
		end
		wait_frames(1); // this frame mixed while the volumes changed
		check_en = 1'b1;
		wait_frames(4);

		// mute rule: voice 2 silent on the left, voice 3 has L0 = 0
		check_en = 1'b0;
		for (int v = 0; v < 8; v++) begin
			apb_write(wsg_pkg::VOICE_BASE + 10'(4*v), 32'd0, 4'b0011, err);
		end
		apb_write(wsg_pkg::VOICE_BASE + 10'h8, 32'h000000f7, 4'b0011, err);
		apb_write(wsg_pkg::VOICE_BASE + 10'hc, 32'h00000f00, 4'b0011, err);
		apb_write(10'h080, 32'h80808080, 4'hf, err); // voice 2 word 0
		apb_write(10'h0c0, 32'h80808080, 4'hf, err); // voice 3 word 0
		wait_frames(1);
		check_en = 1'b1;
		wait_frames(2);
		check_eq("o_stereo.left", $unsigned(o_stereo.left), 16'hbfff);   // -128 + -128<<15
		check_eq("o_stereo.right", $unsigned(o_stereo.right), 16'hbfc0); // shifts 0 and 8

		// ramp on voices 0 and 1, left only and right only
		check_en = 1'b0;
		for (int w = 0; w < 32; w++) begin
			apb_write(10'(4*w), {8'(4*(w%16)), 8'(4*(w%16)+1), 8'(4*(w%16)+2),
				8'(4*(w%16)+3)}, 4'hf, err);
		end
		apb_write(wsg_pkg::VOICE_BASE + 10'h0, 32'h0000f000, 4'b0011, err);
		apb_write(wsg_pkg::VOICE_BASE + 10'h4, 32'h000000f0, 4'b0011, err);
		apb_write(wsg_pkg::VOICE_BASE + 10'h8, 32'd0, 4'b0011, err);
		apb_write(wsg_pkg::VOICE_BASE + 10'hc, 32'd0, 4'b0011, err);
		wait_frames(1);
		check_en = 1'b1;
		// freq lands before the next phase window, positions are still 0
		apb_write(wsg_pkg::VOICE_BASE + 10'h0, 32'h00080000, 4'b1100, err); // 0x0800
		apb_write(wsg_pkg::VOICE_BASE + 10'h4, 32'h00040000, 4'b1100, err); // 0x0400
		for (int k = 1; k <= 70; k++) begin // runs past the wrap at 64
			wait_frames(1);
			// full volume nybble puts the ramp value 7 bits up in the output
			check_eq("o_stereo.left", $unsigned(o_stereo.left), 32'((k % 64) * 128));
			check_eq("o_stereo.right", $unsigned(o_stereo.right), 32'(((k / 2) % 64) * 128));
		end

		$display("** PASS **");
		$finish;
	end

endmodule

// ==== project.f ====
source/wsg_pkg.sv
source/wsg_apb_regs.sv
source/wsg_wave_ram.sv
source/wsg_sequencer.sv
source/wsg_phase.sv
source/wsg_mixer.sv
source/wsg_top.sv
tests/wsg_sva.sv
tests/wsg_tb.sv

// ==== Bender.yml ====
package:
  name: wsg

sources:
  - files:
      - source/wsg_pkg.sv
      - source/wsg_apb_regs.sv
      - source/wsg_wave_ram.sv
      - source/wsg_sequencer.sv
      - source/wsg_phase.sv
      - source/wsg_mixer.sv
      - source/wsg_top.sv
  - target: test
    files:
      - tests/wsg_sva.sv
      - tests/wsg_tb.sv
